// ==== source/rowbuf_geom_pkg.sv ====
package rowbuf_geom_pkg;

    ////////////////////
    // Memory geometry
    ////////////////////

    // One pixel of the feature map
    localparam int PIXEL_WIDTH = 16;

    // Each bank holds two rows of up to 256 columns
    localparam int BANK_DEPTH = 512;

    localparam int COL_WIDTH = 8;

    // Column plus the half-select bit on top
    localparam int BANK_ADDR_WIDTH = COL_WIDTH + 1;

    ////////////////////
    // Pipeline depths
    ////////////////////

    // Execute strobe to valid pixel pair
    localparam int READ_LATENCY = 3;

    // Incoming-row pixels lag the prefetch buffer by two cycles
    localparam int PIXEL_DELAY = 2;
    localparam int MATRIC_DELAY = 1;

    typedef logic [PIXEL_WIDTH-1:0]     pixel_t;
    typedef logic [COL_WIDTH-1:0]       col_t;
    typedef logic [BANK_ADDR_WIDTH-1:0] bank_addr_t;

    // Bank 1 pixel in the upper half, bank 0 pixel in the lower half
    typedef logic [2*PIXEL_WIDTH-1:0]   pixel_pair_t;

endpackage

// ==== source/awe_seq_pkg.sv ====
package awe_seq_pkg;

    ////////////////////
    // Window engine phases
    ////////////////////

    typedef enum logic [2:0] {
        idle           = 3'd0,
        prim_buffer    = 3'd1,
        wait_pfb_load  = 3'd2,
        active         = 3'd3,
        fin_row_matric = 3'd4,
        job_done       = 3'd5
    } awe_phase_t;

    // Row rotation code, steps through 00 01 11 10
    typedef logic [1:0] gray_t;

    ////////////////////
    // Sequence word layout
    ////////////////////

    typedef logic [15:0] seq_word_t;

    // Selects which of the two rows in a bank is read
    localparam int SEQ_HALF_BIT = 15;

    // Even column sits in bits 14..7
    localparam int SEQ_EVEN_LSB = 7;

    // Odd column high part sits in bits 6..0, its low bit is always 1
    localparam int SEQ_ODD_LSB = 0;
    localparam int SEQ_ODD_WIDTH = 7;

endpackage

// ==== source/row_write_ctrl.sv ====
`timescale 1ns/1ps

module row_write_ctrl (
    input  logic                      clk,
    input  logic                      rst,
    input  awe_seq_pkg::awe_phase_t   phase,
    input  awe_seq_pkg::gray_t        gray,
    input  rowbuf_geom_pkg::col_t     num_cols,
    input  logic                      pixel_strobe,
    input  rowbuf_geom_pkg::col_t     in_row,
    input  rowbuf_geom_pkg::col_t     in_col,
    input  rowbuf_geom_pkg::pixel_t   pixel_in,
    input  logic                      row_matric,
    input  logic                      last_kernel,
    input  rowbuf_geom_pkg::col_t     wr_col,
    output logic                      wr_en0,
    output logic                      wr_en1,
    output rowbuf_geom_pkg::bank_addr_t wr_addr0,
    output rowbuf_geom_pkg::bank_addr_t wr_addr1,
    output rowbuf_geom_pkg::pixel_t   wr_data0,
    output rowbuf_geom_pkg::pixel_t   wr_data1
);

    rowbuf_geom_pkg::pixel_t     pixel_dly [rowbuf_geom_pkg::PIXEL_DELAY];
    logic                        matric_dly [rowbuf_geom_pkg::MATRIC_DELAY];

    logic                        prim_hit;
    logic                        row_hit;

    logic                        en0_nxt;
    logic                        en1_nxt;
    rowbuf_geom_pkg::bank_addr_t addr0_nxt;
    rowbuf_geom_pkg::bank_addr_t addr1_nxt;
    rowbuf_geom_pkg::pixel_t     data0_nxt;
    rowbuf_geom_pkg::pixel_t     data1_nxt;

    ////////////////////
    // Delay lines
    ////////////////////

    // Line up incoming-row pixels and strobe with the prefetch latency
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < rowbuf_geom_pkg::PIXEL_DELAY; i++) begin
                pixel_dly[i] <= '0;
            end
            for (int i = 0; i < rowbuf_geom_pkg::MATRIC_DELAY; i++) begin
                matric_dly[i] <= 1'b0;
            end
        end else begin
            pixel_dly[0]  <= pixel_in;
            matric_dly[0] <= row_matric;
            for (int i = 1; i < rowbuf_geom_pkg::PIXEL_DELAY; i++) begin
                pixel_dly[i] <= pixel_dly[i-1];
            end
            for (int i = 1; i < rowbuf_geom_pkg::MATRIC_DELAY; i++) begin
                matric_dly[i] <= matric_dly[i-1];
            end
        end
    end

    ////////////////////
    // Write decode
    ////////////////////

    assign prim_hit = (phase == awe_seq_pkg::prim_buffer) && pixel_strobe
                      && (in_col <= num_cols);

    assign row_hit = ((phase == awe_seq_pkg::active) || (phase == awe_seq_pkg::fin_row_matric))
                     && matric_dly[rowbuf_geom_pkg::MATRIC_DELAY-1] && last_kernel;

    always_comb begin
        en0_nxt   = 1'b0;
        en1_nxt   = 1'b0;
        addr0_nxt = wr_addr0;
        addr1_nxt = wr_addr1;
        data0_nxt = wr_data0;
        data1_nxt = wr_data1;

        // Row 0 is shared, rows 1 and 2 fill the upper halves
        if (prim_hit) begin
            case (in_row)
                8'd0: begin
                    en0_nxt   = 1'b1;
                    en1_nxt   = 1'b1;
                    addr0_nxt = {1'b0, in_col};
                    addr1_nxt = {1'b0, in_col};
                    data0_nxt = pixel_in;
                    data1_nxt = pixel_in;
                end
                8'd1: begin
                    en1_nxt   = 1'b1;
                    addr1_nxt = {1'b1, in_col};
                    data1_nxt = pixel_in;
                end
                8'd2: begin
                    en0_nxt   = 1'b1;
                    addr0_nxt = {1'b1, in_col};
                    data0_nxt = pixel_in;
                end
                default: ;
            endcase
        end

        // Incoming row overrides priming on the same bank
        if (row_hit) begin
            if (gray[0] == gray[1]) begin
                en1_nxt   = 1'b1;
                addr1_nxt = {gray[0], wr_col};
                data1_nxt = pixel_dly[rowbuf_geom_pkg::PIXEL_DELAY-1];
            end else begin
                en0_nxt   = 1'b1;
                addr0_nxt = {gray[0], wr_col};
                data0_nxt = pixel_dly[rowbuf_geom_pkg::PIXEL_DELAY-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_en0 <= 1'b0;
            wr_en1 <= 1'b0;
        end else begin
            wr_en0 <= en0_nxt;
            wr_en1 <= en1_nxt;
        end
    end

    always_ff @(posedge clk) begin
        wr_addr0 <= addr0_nxt;
        wr_addr1 <= addr1_nxt;
        wr_data0 <= data0_nxt;
        wr_data1 <= data1_nxt;
    end

endmodule

// ==== source/row_bank_pair.sv ====
`timescale 1ns/1ps

module row_bank_pair (
    input  logic                        clk,
    input  logic                        wr_en0,
    input  logic                        wr_en1,
    input  rowbuf_geom_pkg::bank_addr_t wr_addr0,
    input  rowbuf_geom_pkg::bank_addr_t wr_addr1,
    input  rowbuf_geom_pkg::pixel_t     wr_data0,
    input  rowbuf_geom_pkg::pixel_t     wr_data1,
    input  logic                        rd_en,
    input  rowbuf_geom_pkg::bank_addr_t rd_addr0,
    input  rowbuf_geom_pkg::bank_addr_t rd_addr1,
    output rowbuf_geom_pkg::pixel_t     rd_data0,
    output rowbuf_geom_pkg::pixel_t     rd_data1
);

    logic                        wr_en_v   [2];
    rowbuf_geom_pkg::bank_addr_t wr_addr_v [2];
    rowbuf_geom_pkg::pixel_t     wr_data_v [2];
    rowbuf_geom_pkg::bank_addr_t rd_addr_v [2];
    rowbuf_geom_pkg::pixel_t     rd_q      [2];

    assign wr_en_v[0]   = wr_en0;
    assign wr_en_v[1]   = wr_en1;
    assign wr_addr_v[0] = wr_addr0;
    assign wr_addr_v[1] = wr_addr1;
    assign wr_data_v[0] = wr_data0;
    assign wr_data_v[1] = wr_data1;
    assign rd_addr_v[0] = rd_addr0;
    assign rd_addr_v[1] = rd_addr1;

    // One simple dual-port RAM per bank, reads see the old word on collision
    for (genvar b = 0; b < 2; b++) begin : g_bank
        rowbuf_geom_pkg::pixel_t mem [rowbuf_geom_pkg::BANK_DEPTH];

        always_ff @(posedge clk) begin
            if (wr_en_v[b]) begin
                mem[wr_addr_v[b]] <= wr_data_v[b];
            end
            if (rd_en) begin
                rd_q[b] <= mem[rd_addr_v[b]];
            end
        end
    end

    assign rd_data0 = rd_q[0];
    assign rd_data1 = rd_q[1];

endmodule

// ==== source/window_read_ctrl.sv ====
`timescale 1ns/1ps

module window_read_ctrl (
    input  logic                         clk,
    input  logic                         rst,
    input  awe_seq_pkg::awe_phase_t      phase,
    input  awe_seq_pkg::gray_t           gray,
    input  logic                         execute,
    input  awe_seq_pkg::seq_word_t       seq,
    input  rowbuf_geom_pkg::pixel_t      rd_data0,
    input  rowbuf_geom_pkg::pixel_t      rd_data1,
    output logic                         rd_en,
    output rowbuf_geom_pkg::bank_addr_t  rd_addr0,
    output rowbuf_geom_pkg::bank_addr_t  rd_addr1,
    output rowbuf_geom_pkg::pixel_pair_t dout,
    output logic                         dout_valid
);

    logic                                    seq_half;
    rowbuf_geom_pkg::col_t                   even_col;
    logic [awe_seq_pkg::SEQ_ODD_WIDTH-1:0]   odd_hi;
    logic                                    rd_vld;

    ////////////////////
    // Sequence decode
    ////////////////////

    assign seq_half = seq[awe_seq_pkg::SEQ_HALF_BIT];
    assign even_col = seq[awe_seq_pkg::SEQ_EVEN_LSB +: rowbuf_geom_pkg::COL_WIDTH];
    assign odd_hi   = seq[awe_seq_pkg::SEQ_ODD_LSB +: awe_seq_pkg::SEQ_ODD_WIDTH];

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_en <= 1'b0;
        end else begin
            rd_en <= execute && (phase == awe_seq_pkg::active);
        end
    end

    // Gray code rotates which half holds each logical row
    always_ff @(posedge clk) begin
        if (execute) begin
            rd_addr0 <= {gray[0] ^ seq_half, even_col};
            rd_addr1 <= {gray[1] ^ seq_half, odd_hi, 1'b1};
        end
    end

    ////////////////////
    // Output stage
    ////////////////////

    // Bank data is ready one cycle after rd_en
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_vld     <= 1'b0;
            dout_valid <= 1'b0;
        end else begin
            rd_vld     <= rd_en;
            dout_valid <= rd_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_vld) begin
            dout <= {rd_data1, rd_data0};
        end
    end

endmodule

// ==== source/awe_rowbuffer.sv ====
`timescale 1ns/1ps

module awe_rowbuffer (
    input  logic                         clk,
    input  logic                         rst,
    input  awe_seq_pkg::awe_phase_t      phase,
    input  awe_seq_pkg::gray_t           gray,
    input  rowbuf_geom_pkg::col_t        num_cols,
    input  rowbuf_geom_pkg::pixel_t      pixel_in,
    input  logic                         pixel_strobe,
    input  rowbuf_geom_pkg::col_t        in_row,
    input  rowbuf_geom_pkg::col_t        in_col,
    input  logic                         execute,
    input  awe_seq_pkg::seq_word_t       seq,
    input  logic                         row_matric,
    input  logic                         last_kernel,
    input  rowbuf_geom_pkg::col_t        wr_col,
    output rowbuf_geom_pkg::pixel_pair_t dout,
    output logic                         dout_valid
);

    logic                        wr_en0;
    logic                        wr_en1;
    rowbuf_geom_pkg::bank_addr_t wr_addr0;
    rowbuf_geom_pkg::bank_addr_t wr_addr1;
    rowbuf_geom_pkg::pixel_t     wr_data0;
    rowbuf_geom_pkg::pixel_t     wr_data1;
    logic                        rd_en;
    rowbuf_geom_pkg::bank_addr_t rd_addr0;
    rowbuf_geom_pkg::bank_addr_t rd_addr1;
    rowbuf_geom_pkg::pixel_t     rd_data0;
    rowbuf_geom_pkg::pixel_t     rd_data1;

    // Priming and incoming-row writes
    row_write_ctrl i_write_ctrl (
        .clk          (clk),
        .rst          (rst),
        .phase        (phase),
        .gray         (gray),
        .num_cols     (num_cols),
        .pixel_strobe (pixel_strobe),
        .in_row       (in_row),
        .in_col       (in_col),
        .pixel_in     (pixel_in),
        .row_matric   (row_matric),
        .last_kernel  (last_kernel),
        .wr_col       (wr_col),
        .wr_en0       (wr_en0),
        .wr_en1       (wr_en1),
        .wr_addr0     (wr_addr0),
        .wr_addr1     (wr_addr1),
        .wr_data0     (wr_data0),
        .wr_data1     (wr_data1)
    );

    row_bank_pair i_bank_pair (
        .clk      (clk),
        .wr_en0   (wr_en0),
        .wr_en1   (wr_en1),
        .wr_addr0 (wr_addr0),
        .wr_addr1 (wr_addr1),
        .wr_data0 (wr_data0),
        .wr_data1 (wr_data1),
        .rd_en    (rd_en),
        .rd_addr0 (rd_addr0),
        .rd_addr1 (rd_addr1),
        .rd_data0 (rd_data0),
        .rd_data1 (rd_data1)
    );

    // Pixel pair reads for the convolution engine
    window_read_ctrl i_read_ctrl (
        .clk        (clk),
        .rst        (rst),
        .phase      (phase),
        .gray       (gray),
        .execute    (execute),
        .seq        (seq),
        .rd_data0   (rd_data0),
        .rd_data1   (rd_data1),
        .rd_en      (rd_en),
        .rd_addr0   (rd_addr0),
        .rd_addr1   (rd_addr1),
        .dout       (dout),
        .dout_valid (dout_valid)
    );

endmodule

// ==== bench/awe_rowbuffer_checker.sv ====
`timescale 1ns/1ps

module awe_rowbuffer_checker (
    input logic                    clk,
    input logic                    rst,
    input awe_seq_pkg::awe_phase_t phase,
    input logic                    execute,
    input logic                    dout_valid,
    input logic                    wr_en0,
    input logic                    wr_en1
);

    logic exec_active;

    // Set once any assertion has fired
    logic failed = 1'b0;

    assign exec_active = execute && (phase == awe_seq_pkg::active);

    a_valid_follows: assert property (@(posedge clk) disable iff (rst)
        $past(exec_active, rowbuf_geom_pkg::READ_LATENCY) |-> dout_valid)
    else begin
        failed = 1'b1;
        $error("dout_valid missing after an execute in phase active");
    end

    // No valid without a matching execute three cycles back
    a_valid_source: assert property (@(posedge clk) disable iff (rst)
        dout_valid |-> $past(exec_active, rowbuf_geom_pkg::READ_LATENCY))
    else begin
        failed = 1'b1;
        $error("dout_valid high without an execute in phase active");
    end

    a_reset_quiet: assert property (@(posedge clk)
        rst |=> (!wr_en0 && !wr_en1))
    else begin
        failed = 1'b1;
        $error("Bank write enable high in the cycle after reset");
    end

endmodule

bind awe_rowbuffer awe_rowbuffer_checker i_checker (
    .clk        (clk),
    .rst        (rst),
    .phase      (phase),
    .execute    (execute),
    .dout_valid (dout_valid),
    .wr_en0     (wr_en0),
    .wr_en1     (wr_en1)
);

// ==== bench/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Reset spans two rising edges, released 1 ns after the second
    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

// ==== bench/tb_awe_rowbuffer.sv ====
`timescale 1ns/1ps

module tb_awe_rowbuffer;

    logic                         clk;
    logic                         rst;
    awe_seq_pkg::awe_phase_t      phase;
    awe_seq_pkg::gray_t           gray;
    rowbuf_geom_pkg::col_t        num_cols;
    rowbuf_geom_pkg::pixel_t      pixel_in;
    logic                         pixel_strobe;
    rowbuf_geom_pkg::col_t        in_row;
    rowbuf_geom_pkg::col_t        in_col;
    logic                         execute;
    awe_seq_pkg::seq_word_t       seq;
    logic                         row_matric;
    logic                         last_kernel;
    rowbuf_geom_pkg::col_t        wr_col;
    rowbuf_geom_pkg::pixel_pair_t dout;
    logic                         dout_valid;

    string                        cmd_lines [$];
    string                        exp_name  [$];
    rowbuf_geom_pkg::pixel_pair_t exp_pair  [$];
    bit                           loaded = 1'b0;

    tb_clock_gen i_clock_gen (.clk (clk), .rst (rst));

    awe_rowbuffer i_dut (.*);

    ////////////////////
    // Helpers
    ////////////////////

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("** Error: test %s expected %h actual %h",
                                name, expected, actual));
        end
    endtask

    // Inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic load_commands();
        int    fd;
        string line;
        fd = $fopen("bench/rowbuffer_input.txt", "r");
        if (fd == 0) begin
            abort_run("Cannot open bench/rowbuffer_input.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line.getc(0) != "#") begin
                    cmd_lines.push_back(line);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_command(input string line);
        string       name;
        string       kind;
        logic [2:0]  ph;
        logic [1:0]  gr;
        logic [15:0] idx;
        logic [15:0] value;
        logic        last;
        logic [31:0] expected;
        int          n;
        n = $sscanf(line, "%s %s %h %h %h %h %h %h",
                    name, kind, ph, gr, idx, value, last, expected);
        if (n != 8) begin
            abort_run({"Malformed command line in data file: ", line});
        end else begin
            phase = awe_seq_pkg::awe_phase_t'(ph);
            gray  = gr;
            if (kind == "cols") begin
                num_cols = idx[7:0];
                next_cycle();
            end else if (kind == "prime") begin
                pixel_strobe = 1'b1;
                in_row       = idx[15:8];
                in_col       = idx[7:0];
                pixel_in     = value;
                next_cycle();
                pixel_strobe = 1'b0;
            end else if (kind == "execute") begin
                execute = 1'b1;
                seq     = value;
                // Only phase active returns a pair
                if (phase == awe_seq_pkg::active) begin
                    exp_name.push_back(name);
                    exp_pair.push_back(expected);
                end
                next_cycle();
                execute = 1'b0;
            end else if (kind == "matric") begin
                // Pixel leads the strobe by one cycle to meet the delay line
                pixel_in    = value;
                wr_col      = idx[7:0];
                last_kernel = last;
                next_cycle();
                row_matric = 1'b1;
                next_cycle();
                row_matric = 1'b0;
                next_cycle();
            end else if (kind == "idle") begin
                repeat (idx) next_cycle();
            end else begin
                abort_run({"Unknown command in data file: ", kind});
            end
        end
    endtask

    ////////////////////
    // Output compare
    ////////////////////

    // Each valid pair is matched against the oldest outstanding execute
    always @(negedge clk) begin
        if (i_dut.i_checker.failed) begin
            abort_run("An assertion in the bound checker failed");
        end else if (!rst && dout_valid) begin
            if (exp_pair.size() == 0) begin
                abort_run("dout_valid high with no execute outstanding");
            end else begin
                check_value(exp_name.pop_front(), exp_pair.pop_front(), dout);
            end
        end
    end

    initial begin
        wait (loaded);
        repeat (cmd_lines.size() * 10 + 100) @(posedge clk);
        abort_run("Watchdog timeout before the command list finished");
    end

    initial begin
        // Priming strobe held through reset, the write enables must stay low
        phase        = awe_seq_pkg::prim_buffer;
        gray         = '0;
        num_cols     = '0;
        pixel_in     = '0;
        pixel_strobe = 1'b1;
        in_row       = '0;
        in_col       = '0;
        execute      = 1'b0;
        seq          = '0;
        row_matric   = 1'b0;
        last_kernel  = 1'b0;
        wr_col       = '0;
        load_commands();
        loaded = 1'b1;
        @(posedge clk);
        wait (rst == 1'b0);
        phase        = awe_seq_pkg::idle;
        pixel_strobe = 1'b0;
        foreach (cmd_lines[i]) begin
            run_command(cmd_lines[i]);
        end
        repeat (rowbuf_geom_pkg::READ_LATENCY + 1) next_cycle();
        if (cmd_lines.size() == 0 || exp_pair.size() != 0) begin
            abort_run($sformatf("%0d commands run, %0d expected pairs never arrived",
                                cmd_lines.size(), exp_pair.size()));
        end else if (i_dut.i_checker.failed) begin
            abort_run("An assertion in the bound checker failed");
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule

// ==== bench/rowbuffer_input.txt ====
# name command phase gray idx value last_kernel expected_pair, numbers in hex
# prime idx is row<<8 | col, matric idx is wr_col, idle idx is cycles, cols idx is num_cols
set_cols      cols    1 0 0009 0000 0 00000000
prime_r0c2    prime   1 0 0002 a002 0 00000000
prime_r0c3    prime   1 0 0003 a003 0 00000000
prime_r1c2    prime   1 0 0102 a102 0 00000000
prime_r1c3    prime   1 0 0103 a103 0 00000000
prime_r2c2    prime   1 0 0202 a202 0 00000000
prime_r2c3    prime   1 0 0203 a203 0 00000000
skip_row3     prime   1 0 0302 dead 0 00000000
narrow_cols   cols    1 0 0002 0000 0 00000000
skip_col3     prime   1 0 0003 beef 0 00000000
settle        idle    1 0 0002 0000 0 00000000
rd_g0_lo      execute 3 0 0000 0101 0 a003a002
rd_g0_hi      execute 3 0 0000 8101 0 a103a202
rd_g0_col3    execute 3 0 0000 0181 0 a003a003
rd_g1_lo      execute 3 1 0000 0101 0 a003a202
rd_g3_lo      execute 3 3 0000 0101 0 a103a202
rd_g2_lo      execute 3 2 0000 0101 0 a103a002
rd_g2_hi      execute 3 2 0000 8101 0 a003a202
rd_inactive   execute 2 0 0000 0101 0 00000000
gap           idle    3 0 0004 0000 0 00000000
row_g0        matric  3 0 0005 c005 1 00000000
rd_row_g0     execute 3 0 0000 0102 0 c005a002
row_g1        matric  3 1 0004 c104 1 00000000
rd_row_g1     execute 3 1 0000 0201 0 a003c104
row_g3        matric  3 3 0007 c307 1 00000000
rd_row_g3     execute 3 3 0000 0103 0 c307a202
row_no_last   matric  3 0 0003 dead 0 00000000
row_wrong_ph  matric  2 0 0003 beef 1 00000000
rd_kept       execute 3 0 0000 0101 0 a003a002
drain         idle    3 0 0004 0000 0 00000000

// ==== build.f ====
source/rowbuf_geom_pkg.sv
source/awe_seq_pkg.sv
source/row_write_ctrl.sv
source/row_bank_pair.sv
source/window_read_ctrl.sv
source/awe_rowbuffer.sv
bench/awe_rowbuffer_checker.sv
bench/tb_clock_gen.sv
bench/tb_awe_rowbuffer.sv

// ==== Makefile ====
VERILATOR  = verilator
VFLAGS     = --binary --timing --assert --timescale 1ns/1ps
LINT_FLAGS = --lint-only --timing --assert --timescale 1ns/1ps
TOP        = tb_awe_rowbuffer
FILELIST   = build.f
OBJ_DIR    = obj_dir
RUN_FLAGS  = +verilator+error+limit+100
PASS_TEXT  = Everything OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
